// ==== verilog/rv_core_pkg.sv ====
package rv_core_pkg;

  // ==============================
  // widths and basic types
  // ==============================

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [31:0]     inst_t;
  typedef logic [3:0]      alu_op_t;

  // ==============================
  // alu operation codes
  // ==============================

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  // operand b straight through, used by lui
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // ==============================
  // rv32i opcodes
  // ==============================

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

  // fetch pc
  localparam word_t PC_RESET = 32'h0000_0000;
  localparam word_t PC_STEP  = 32'd4;

endpackage

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder
  import rv_core_pkg::*;
(
  input  inst_t     inst_i,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o,
  output word_t     imm_o,
  output alu_op_t   alu_op_o,
  output logic      alu_src_o,
  output logic      pc_src_o,
  output logic      reg_write_o,
  output logic      illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i_type;
  word_t      imm_u_type;
  alu_op_t    arith_op;
  logic       bad_funct7;

  // instruction fields
  assign opcode = inst_i[6:0];
  assign rd_o   = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];
  assign funct7 = inst_i[31:25];

  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u_type = {inst_i[31:12], 12'b0};

  // funct7 bit 5 picks sub / sra, shared by op and op-imm shifts
  always_comb begin
    case (funct3)
      3'b000:  arith_op = funct7[5] ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  // only add/srl may carry the alternate funct7
  assign bad_funct7 = !((funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101)));

  always_comb begin
    alu_op_o    = ALU_ADD;
    alu_src_o   = 1'b0;
    pc_src_o    = 1'b0;
    reg_write_o = 1'b0;
    illegal_o   = 1'b0;
    imm_o       = imm_i_type;
    case (opcode)
      OPC_OP: begin
        alu_op_o    = arith_op;
        reg_write_o = !bad_funct7;
        illegal_o   = bad_funct7;
      end
      OPC_OP_IMM: begin
        // addi has no sub form, imm bits sit where funct7 would be
        alu_op_o    = (funct3 == 3'b000) ? ALU_ADD : arith_op;
        alu_src_o   = 1'b1;
        reg_write_o = 1'b1;
      end
      OPC_LUI: begin
        alu_op_o    = ALU_PASS_B;
        alu_src_o   = 1'b1;
        reg_write_o = 1'b1;
        imm_o       = imm_u_type;
      end
      OPC_AUIPC: begin
        alu_src_o   = 1'b1;
        pc_src_o    = 1'b1;
        reg_write_o = 1'b1;
        imm_o       = imm_u_type;
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  reg_addr_t raddr1_i,
  input  reg_addr_t raddr2_i,
  output word_t     rdata1_o,
  output word_t     rdata2_o,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i
);

  word_t regs [NUM_REGS];
  logic  wr_en;
  logic  bypass1;
  logic  bypass2;

  // x0 is never written
  assign wr_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // write-through for a same-cycle read of the register being written
  assign bypass1 = wr_en && (waddr_i == raddr1_i);
  assign bypass2 = wr_en && (waddr_i == raddr2_i);

  assign rdata1_o = (raddr1_i == '0) ? '0 : (bypass1 ? wdata_i : regs[raddr1_i]);
  assign rdata2_o = (raddr2_i == '0) ? '0 : (bypass2 ? wdata_i : regs[raddr2_i]);

  // write-back never targets x0
  a_no_x0_write : assert property (
    @(posedge clk) disable iff (!rst_n_i) we_i |-> (waddr_i != '0)
  );

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu
  import rv_core_pkg::*;
(
  input  alu_op_t alu_op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // only the low 5 bits shift
  assign shamt = b_i[4:0];

  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD: begin
        result_o = a_i + b_i;
      end
      ALU_SUB: begin
        result_o = a_i - b_i;
      end
      ALU_SLL: begin
        result_o = a_i << shamt;
      end
      ALU_SLT: begin
        result_o = {{(XLEN-1){1'b0}}, lt_signed};
      end
      ALU_SLTU: begin
        result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      end
      ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      ALU_SRL: begin
        result_o = a_i >> shamt;
      end
      ALU_SRA: begin
        result_o = word_t'($signed(a_i) >>> shamt);
      end
      ALU_OR: begin
        result_o = a_i | b_i;
      end
      ALU_AND: begin
        result_o = a_i & b_i;
      end
      ALU_PASS_B: begin
        result_o = b_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  word_t     pc_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  word_t     rdata1_i,
  input  word_t     rdata2_i,
  input  word_t     imm_i,
  input  alu_op_t   alu_op_i,
  input  logic      alu_src_i,
  input  logic      pc_src_i,
  input  logic      reg_write_i,
  input  logic      illegal_i,
  output logic      retire_valid_o,
  output logic      retire_illegal_o,
  output logic      retire_we_o,
  output reg_addr_t retire_rd_o,
  output word_t     retire_wdata_o,
  output word_t     retire_pc_o
);

  word_t opnd1;
  word_t opnd2;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;

  // ==============================
  // forwarding from write-back
  // ==============================

  // retire_we_o already implies a valid, non-zero destination
  assign opnd1 = (retire_we_o && (retire_rd_o == rs1_i)) ? retire_wdata_o : rdata1_i;
  assign opnd2 = (retire_we_o && (retire_rd_o == rs2_i)) ? retire_wdata_o : rdata2_i;

  // auipc takes the pc, immediates go on b
  assign alu_a = pc_src_i  ? pc_i  : opnd1;
  assign alu_b = alu_src_i ? imm_i : opnd2;

  alu alu_i (
    .alu_op_i (alu_op_i),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  // ==============================
  // execute / write-back register
  // ==============================

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      retire_valid_o   <= 1'b0;
      retire_illegal_o <= 1'b0;
      retire_we_o      <= 1'b0;
    end else begin
      retire_valid_o   <= valid_i;
      retire_illegal_o <= valid_i && illegal_i;
      retire_we_o      <= valid_i && reg_write_i && (rd_i != '0);
    end
  end

  // bubbles keep the old payload
  always_ff @(posedge clk) begin
    if (valid_i) begin
      retire_rd_o    <= rd_i;
      retire_wdata_o <= alu_result;
      retire_pc_o    <= pc_i;
    end
  end

  // only a legal retiring instruction writes a register
  a_we_valid : assert property (
    @(posedge clk) disable iff (!rst_n_i)
      retire_we_o |-> (retire_valid_o && !retire_illegal_o)
  );

endmodule

// ==== verilog/int_pipeline.sv ====
`timescale 1ns/1ps

module int_pipeline
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      inst_valid_i,
  input  inst_t     inst_i,
  output logic      retire_valid_o,
  output logic      retire_illegal_o,
  output logic      retire_we_o,
  output reg_addr_t retire_rd_o,
  output word_t     retire_wdata_o,
  output word_t     retire_pc_o
);

  // fetch
  word_t     fetch_pc;

  // fetch / decode register
  logic      if_id_valid;
  inst_t     if_id_inst;
  word_t     if_id_pc;

  // decode outputs
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  word_t     dec_imm;
  alu_op_t   dec_alu_op;
  logic      dec_alu_src;
  logic      dec_pc_src;
  logic      dec_reg_write;
  logic      dec_illegal;
  word_t     dec_rdata1;
  word_t     dec_rdata2;

  // decode / execute register
  logic      id_ex_valid;
  word_t     id_ex_pc;
  reg_addr_t id_ex_rs1;
  reg_addr_t id_ex_rs2;
  reg_addr_t id_ex_rd;
  word_t     id_ex_rdata1;
  word_t     id_ex_rdata2;
  word_t     id_ex_imm;
  alu_op_t   id_ex_alu_op;
  logic      id_ex_alu_src;
  logic      id_ex_pc_src;
  logic      id_ex_reg_write;
  logic      id_ex_illegal;

  // ==============================
  // fetch
  // ==============================

  // pc counts accepted instructions only
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_pc    <= PC_RESET;
      if_id_valid <= 1'b0;
      if_id_inst  <= NOP_INST;
      if_id_pc    <= PC_RESET;
    end else begin
      if_id_valid <= inst_valid_i;
      if (inst_valid_i) begin
        fetch_pc   <= fetch_pc + PC_STEP;
        if_id_inst <= inst_i;
        if_id_pc   <= fetch_pc;
      end
    end
  end

  // ==============================
  // decode
  // ==============================

  inst_decoder inst_decoder_i (
    .inst_i      (if_id_inst),
    .rs1_o       (dec_rs1),
    .rs2_o       (dec_rs2),
    .rd_o        (dec_rd),
    .imm_o       (dec_imm),
    .alu_op_o    (dec_alu_op),
    .alu_src_o   (dec_alu_src),
    .pc_src_o    (dec_pc_src),
    .reg_write_o (dec_reg_write),
    .illegal_o   (dec_illegal)
  );

  // written from the execute / write-back register
  reg_file reg_file_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .raddr1_i (dec_rs1),
    .raddr2_i (dec_rs2),
    .rdata1_o (dec_rdata1),
    .rdata2_o (dec_rdata2),
    .we_i     (retire_we_o),
    .waddr_i  (retire_rd_o),
    .wdata_i  (retire_wdata_o)
  );

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_valid <= 1'b0;
    end else begin
      id_ex_valid <= if_id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (if_id_valid) begin
      id_ex_pc        <= if_id_pc;
      id_ex_rs1       <= dec_rs1;
      id_ex_rs2       <= dec_rs2;
      id_ex_rd        <= dec_rd;
      id_ex_rdata1    <= dec_rdata1;
      id_ex_rdata2    <= dec_rdata2;
      id_ex_imm       <= dec_imm;
      id_ex_alu_op    <= dec_alu_op;
      id_ex_alu_src   <= dec_alu_src;
      id_ex_pc_src    <= dec_pc_src;
      id_ex_reg_write <= dec_reg_write;
      id_ex_illegal   <= dec_illegal;
    end
  end

  // ==============================
  // execute and write-back
  // ==============================

  execute_stage execute_stage_i (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .valid_i          (id_ex_valid),
    .pc_i             (id_ex_pc),
    .rs1_i            (id_ex_rs1),
    .rs2_i            (id_ex_rs2),
    .rd_i             (id_ex_rd),
    .rdata1_i         (id_ex_rdata1),
    .rdata2_i         (id_ex_rdata2),
    .imm_i            (id_ex_imm),
    .alu_op_i         (id_ex_alu_op),
    .alu_src_i        (id_ex_alu_src),
    .pc_src_i         (id_ex_pc_src),
    .reg_write_i      (id_ex_reg_write),
    .illegal_i        (id_ex_illegal),
    .retire_valid_o   (retire_valid_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_we_o      (retire_we_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wdata_o   (retire_wdata_o),
    .retire_pc_o      (retire_pc_o)
  );

  // word aligned fetch pc
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!rst_n_i) fetch_pc[1:0] == 2'b00
  );

endmodule

// ==== testbench/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ==============================
// reference state and lcg
// ==============================

logic [31:0] lcg_state;
logic [31:0] ref_regs [32];
logic [31:0] ref_pc;

// funct3 per operation index
// r-type: add sub sll slt sltu xor srl sra or and
localparam logic [2:0] R_FUNCT3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                         3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
// i-type: addi slti sltiu xori ori andi slli srli srai
localparam logic [2:0] I_FUNCT3 [9] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6,
                                        3'd7, 3'd1, 3'd5, 3'd5};

function automatic void init_model();
  lcg_state = 32'd88774;
  ref_pc = 32'h0;
  for (int i = 0; i < 32; i++) begin
    ref_regs[i] = 32'h0;
  end
endfunction

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

function automatic int unsigned rand_below(input int unsigned n);
  logic [31:0] r;
  // low bits of the lcg repeat too quickly
  r = lcg_next();
  return (r >> 8) % n;
endfunction

function automatic logic [31:0] rand_word();
  logic [31:0] hi;
  logic [31:0] lo;
  hi = lcg_next();
  lo = lcg_next();
  return {hi[31:16], lo[31:16]};
endfunction

function automatic logic [4:0] rand_reg();
  return 5'(rand_below(32));
endfunction

function automatic logic [4:0] rand_dest();
  return 5'(rand_below(31) + 1);
endfunction

// ==============================
// instruction encoders
// ==============================

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] r_op(input int idx, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
  logic [6:0] f7;
  // sub and sra
  f7 = (idx == 1 || idx == 7) ? 7'h20 : 7'h00;
  return enc_r(f7, rs2, rs1, R_FUNCT3[idx], rd);
endfunction

function automatic logic [31:0] i_op(input int idx, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [11:0] imm);
  logic [11:0] imm_f;
  imm_f = imm;
  // shifts keep a 5 bit amount, srai sets bit 30
  if (idx >= 6) begin
    imm_f = {(idx == 8) ? 7'h20 : 7'h00, imm[4:0]};
  end
  return enc_i(imm_f, rs1, I_FUNCT3[idx], rd, 7'h13);
endfunction

// ==============================
// reference execute
// ==============================

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = {31'b0, $signed(a) < $signed(b)};
    3'd3: r = {31'b0, a < b};
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt) begin
        r = $signed(a) >>> b[4:0];
      end else begin
        r = a >> b[4:0];
      end
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

function automatic void ref_execute(input logic [31:0] inst, output logic ill,
                                    output logic we, output logic [4:0] rd,
                                    output logic [31:0] wdata, output logic [31:0] pc);
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  f3    = inst[14:12];
  f7    = inst[31:25];
  rd    = inst[11:7];
  a     = ref_regs[inst[19:15]];
  b     = ref_regs[inst[24:20]];
  imm   = {{20{inst[31]}}, inst[31:20]};
  pc    = ref_pc;
  ill   = 1'b0;
  wdata = 32'h0;
  case (inst[6:0])
    7'h33: begin
      ill   = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
      wdata = alu_ref(f3, f7 == 7'h20, a, b);
    end
    7'h13: wdata = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm);
    7'h37: wdata = {inst[31:12], 12'h0};
    7'h17: wdata = ref_pc + {inst[31:12], 12'h0};
    default: ill = 1'b1;
  endcase
  we = !ill && (rd != 5'd0);
  if (we) begin
    ref_regs[rd] = wdata;
  end
  ref_pc = ref_pc + 32'd4;
endfunction

`endif

// ==== testbench/tb_int_pipeline.sv ====
`timescale 1ns/1ps

module tb_int_pipeline;

  localparam int RESET_CYCLES = 16;
  localparam int RETIRE_EDGES = 3;
  // slots of all six tests, bubbles included
  localparam int TEST_SLOTS = 40 + 262 + 200 + 180 + 160 + 61;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_SLOTS + 50;

  logic        clk;
  logic        rst_n_i;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic        retire_valid_o;
  logic        retire_illegal_o;
  logic        retire_we_o;
  logic [4:0]  retire_rd_o;
  logic [31:0] retire_wdata_o;
  logic [31:0] retire_pc_o;

  int edge_count = 0;
  int error_count = 0;
  int check_count = 0;

  // {sample edge, pc, wdata, rd, we, illegal}
  logic [102:0] expect_q [$];

  `include "tb_ref_model.svh"

  int_pipeline int_pipeline_i (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .inst_valid_i     (inst_valid_i),
    .inst_i           (inst_i),
    .retire_valid_o   (retire_valid_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_we_o      (retire_we_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wdata_o   (retire_wdata_o),
    .retire_pc_o      (retire_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    edge_count++;
    if (edge_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic issue_inst(input logic [31:0] inst);
    logic        ill;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic [31:0] pc;
    ref_execute(inst, ill, we, rd, wdata, pc);
    expect_q.push_back({32'(edge_count + 1), pc, wdata, rd, we, ill});
    inst_valid_i = 1'b1;
    inst_i = inst;
    @(posedge clk);
    #2;
    inst_valid_i = 1'b0;
  endtask

  task automatic insert_bubble();
    inst_valid_i = 1'b0;
    // junk on the bus while the strobe is low
    inst_i = rand_word();
    @(posedge clk);
    #2;
  endtask

  // ==============================
  // retire compare
  // ==============================

  always @(negedge clk) begin : compare_retire
    logic [102:0] rec;
    if (rst_n_i && retire_valid_o) begin
      if (expect_q.size() == 0) begin
        error_count++;
        $display("retire at %0t with no instruction outstanding", $time);
      end else begin
        rec = expect_q.pop_front();
        // write-back happens on the coming edge
        check_value("retire edge", 32'(edge_count + 1), rec[102:71] + RETIRE_EDGES);
        check_value("retire pc", retire_pc_o, rec[70:39]);
        check_value("retire illegal", 32'(retire_illegal_o), 32'(rec[0]));
        check_value("retire we", 32'(retire_we_o), 32'(rec[1]));
        check_value("retire rd", 32'(retire_rd_o), 32'(rec[6:2]));
        if (!rec[0]) begin
          check_value("retire wdata", retire_wdata_o, rec[38:7]);
        end
      end
    end
  end

  initial begin
    logic [31:0] w;
    logic [4:0]  rp;
    logic [6:0]  opc;
    int          gaps;
    init_model();
    rst_n_i = 1'b0;
    inst_valid_i = 1'b0;
    inst_i = 32'h0000_0013;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    check_value("valid after reset", 32'(retire_valid_o), 32'h0);
    check_value("we after reset", 32'(retire_we_o), 32'h0);
    check_value("illegal after reset", 32'(retire_illegal_o), 32'h0);

    // idle, then add x0 + x0 into every register
    repeat (8) insert_bubble();
    for (int r = 0; r < 32; r++) begin
      issue_inst(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'(r)));
    end

    // lui/addi loads, then all ten r-type ops
    for (int r = 1; r < 32; r++) begin
      w = rand_word();
      issue_inst(enc_u(w[31:12], 5'(r), 7'h37));
      issue_inst(enc_i(w[11:0], 5'(r), 3'd0, 5'(r), 7'h13));
    end
    for (int n = 0; n < 200; n++) begin
      issue_inst(r_op(n % 10, rand_reg(), rand_reg(), rand_reg()));
    end

    // i-type incl. shifts and negative immediates
    for (int n = 0; n < 200; n++) begin
      w = rand_word();
      issue_inst(i_op(n % 9, rand_reg(), rand_reg(), w[11:0]));
    end

    // distance 1 forwards, 2 writes through, 3 reads the file
    for (int d = 1; d <= 3; d++) begin
      for (int k = 0; k < 20; k++) begin
        rp = rand_dest();
        w = rand_word();
        issue_inst(i_op(0, rp, rand_reg(), w[11:0]));
        for (int f = 1; f < d; f++) begin
          w = rand_word();
          issue_inst(i_op(0, rp ^ 5'h10, rand_reg(), w[11:0]));
        end
        issue_inst(r_op(k % 10, rand_reg(), rp, (rand_below(2) == 0) ? rp : rand_reg()));
      end
    end

    // auipc with random gaps in the strobe
    for (int n = 0; n < 40; n++) begin
      gaps = rand_below(4);
      repeat (gaps) insert_bubble();
      w = rand_word();
      issue_inst(enc_u(w[19:0], rand_dest(), 7'h17));
    end

    // x0 writes, each followed at once by an x0 read
    for (int n = 0; n < 10; n++) begin
      w = rand_word();
      if (n % 2 == 0) begin
        issue_inst(enc_u(w[31:12], 5'd0, 7'h37));
      end else begin
        issue_inst(i_op(n % 9, 5'd0, rand_reg(), w[11:0]));
      end
      issue_inst(enc_r(7'h00, 5'd0, 5'd0, 3'd0, rand_dest()));
    end
    // unknown opcodes and a mul/div funct7
    for (int n = 0; n < 10; n++) begin
      w = rand_word();
      if (n % 2 == 0) begin
        opc = w[6:0];
        if (opc inside {7'h33, 7'h13, 7'h37, 7'h17}) begin
          opc = opc ^ 7'h40;
        end
        issue_inst({w[31:12], rand_dest(), opc});
      end else begin
        issue_inst(enc_r(7'h01, rand_reg(), rand_reg(), w[14:12], rand_dest()));
      end
    end
    // read back every register unchanged
    for (int r = 1; r < 32; r++) begin
      issue_inst(enc_r(7'h00, 5'd0, 5'(r), 3'd0, 5'(r)));
    end

    repeat (RETIRE_EDGES + 4) @(posedge clk);
    if (expect_q.size() != 0) begin
      error_count++;
      $display("%0d instructions never retired", expect_q.size());
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+testbench
verilog/rv_core_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/int_pipeline.sv
testbench/tb_int_pipeline.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_int_pipeline \
  -f list.f --Mdir obj_dir -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
